/* run.sh */
#!/bin/bash
# Build and run the Reed-Solomon encoder testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f verilog.f \
   --top-module rsEncoderTb \
   -o rsEncoderSim

# the simulator's own status is ignored here, the log decides
./obj_dir/rsEncoderSim 2>&1 | tee sim.log

if grep -q "Verification passed" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed"
   exit 1
fi

/* src/rsEncoderTop.sv */
// Reed-Solomon encoder top level, GF(2^8), systematic.
// Passes the data bytes of each codeword through unchanged and
// appends the parity bytes on the same byte stream. The frame
// sequencer and the parity chain run side by side, and the output
// selector merges their results.

`timescale 1ns/1ps

module rsEncoderTop #(
   parameter int dataLength = rsFramePkg::dataSymbols,
   parameter int parityLength = rsFramePkg::paritySymbols,
   parameter int codewordLength = rsFramePkg::codewordSymbols
) (
   input  logic                               CLK,
   input  logic                               RESET,
   input  logic                               enable,     // clock enable, stalls the frame
   input  logic                               startPls,   // marks data symbol 0
   input  logic [rsFieldPkg::symbolWidth-1:0] dataIn,
   output logic [rsFieldPkg::symbolWidth-1:0] dataOut
);

   logic                               clearChain;
   logic                               dataPhase;
   logic                               parityPhase;
   logic [rsFramePkg::countWidth-1:0]  count;        // seen by the bound checks
   logic [rsFieldPkg::symbolWidth-1:0] parityTail;

   // -------------------------------------------------------------------------
   // frame sequencer
   // -------------------------------------------------------------------------
   rsFrameSequencer #(
      .dataLength     (dataLength),
      .codewordLength (codewordLength)
   ) sequencer0 (
      .CLK         (CLK),
      .RESET       (RESET),
      .enable      (enable),
      .startPls    (startPls),
      .clearChain  (clearChain),
      .dataPhase   (dataPhase),
      .parityPhase (parityPhase),
      .count       (count)
   );

   // -------------------------------------------------------------------------
   // parity chain
   // -------------------------------------------------------------------------
   rsParityGenerator #(
      .parityLength (parityLength)
   ) parity0 (
      .CLK        (CLK),
      .RESET      (RESET),
      .enable     (enable),
      .clearChain (clearChain),
      .dataPhase  (dataPhase),
      .dataIn     (dataIn),
      .parityTail (parityTail)
   );

   // -------------------------------------------------------------------------
   // output stream
   // -------------------------------------------------------------------------
   rsOutputSelector selector0 (
      .CLK         (CLK),
      .RESET       (RESET),
      .enable      (enable),
      .parityPhase (parityPhase),
      .dataIn      (dataIn),
      .parityTail  (parityTail),
      .dataOut     (dataOut)
   );

endmodule

/* src/rsFieldPkg.sv */
// GF(2^8) field package for the Reed-Solomon encoder.
// Holds the symbol width, the field polynomial and the constant
// functions that multiply two symbols and build the generator
// polynomial coefficients at elaboration time.

package rsFieldPkg;

   localparam int symbolWidth = 8;
   localparam logic [symbolWidth:0] fieldPoly = 9'h11D;   // x^8+x^4+x^3+x^2+1
   localparam logic [symbolWidth-1:0] alpha = 8'h02;      // primitive element
   localparam int maxOrder = 255;                         // longest generator

   // -------------------------------------------------------------------------
   // symbol product, shift and add with reduction by fieldPoly
   // -------------------------------------------------------------------------
   function automatic logic [symbolWidth-1:0] gfMul(
      input logic [symbolWidth-1:0] a,
      input logic [symbolWidth-1:0] b
   );
      logic [symbolWidth-1:0] prod;
      logic [symbolWidth-1:0] aShift;
      int i;
      prod = '0;
      aShift = a;
      for (i = 0; i < symbolWidth; i++) begin
         if (b[i]) begin
            prod = prod ^ aShift;
         end
         // multiply by x, fold the x^8 term back in
         if (aShift[symbolWidth-1]) begin
            aShift = {aShift[symbolWidth-2:0], 1'b0} ^ fieldPoly[symbolWidth-1:0];
         end
         else begin
            aShift = {aShift[symbolWidth-2:0], 1'b0};
         end
      end
      return prod;
   endfunction

   // -------------------------------------------------------------------------
   // coefficient of x^index in g(x) = prod (x - alpha^j), j = 0..parityLength-1
   // -------------------------------------------------------------------------
   function automatic logic [symbolWidth-1:0] generatorCoeff(
      input int parityLength,
      input int index
   );
      logic [symbolWidth-1:0] coeff [0:maxOrder];
      logic [symbolWidth-1:0] root;
      int j;
      int k;
      for (k = 0; k <= maxOrder; k++) begin
         coeff[k] = '0;
      end
      coeff[0] = 8'h01;   // start from g(x) = 1
      root = 8'h01;       // alpha^0
      for (j = 0; j < parityLength; j++) begin
         // times (x + root), minus equals plus here
         for (k = j + 1; k > 0; k--) begin
            coeff[k] = coeff[k-1] ^ gfMul(coeff[k], root);
         end
         coeff[0] = gfMul(coeff[0], root);
         root = gfMul(root, alpha);
      end
      return coeff[index];
   endfunction

endpackage

/* src/rsFramePkg.sv */
// Codeword format package for the Reed-Solomon encoder.
// Gives the data and parity lengths of one codeword and the width
// of the symbol position counter.

package rsFramePkg;

   // -------------------------------------------------------------------------
   // codeword layout
   // -------------------------------------------------------------------------
   localparam int dataSymbols = 192;     // data bytes, sent first
   localparam int paritySymbols = 16;    // parity bytes, appended
   localparam int codewordSymbols = dataSymbols + paritySymbols;

   // position counter must hold codewordSymbols itself
   localparam int countWidth = 8;

endpackage

/* src/rsFrameSequencer.sv */
// Frame sequencer of the Reed-Solomon encoder.
// Counts symbol positions from the start pulse, idles after the
// last parity symbol and derives the phase flags that steer the
// parity chain and the output selector.

`timescale 1ns/1ps

module rsFrameSequencer #(
   parameter int dataLength = rsFramePkg::dataSymbols,
   parameter int codewordLength = rsFramePkg::codewordSymbols
) (
   input  logic                             CLK,
   input  logic                             RESET,
   input  logic                             enable,
   input  logic                             startPls,
   output logic                             clearChain,
   output logic                             dataPhase,
   output logic                             parityPhase,
   output logic [rsFramePkg::countWidth-1:0] count
);

   localparam logic [rsFramePkg::countWidth-1:0] dataEnd =
      dataLength[rsFramePkg::countWidth-1:0];
   localparam logic [rsFramePkg::countWidth-1:0] lastCount =
      codewordLength[rsFramePkg::countWidth-1:0];

   // -------------------------------------------------------------------------
   // position counter
   // -------------------------------------------------------------------------
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         count <= '0;
      end
      else if (enable) begin
         if (startPls) begin
            count <= 1;                      // position 0 taken on this edge
         end
         else if ((count == '0) || (count == lastCount)) begin
            count <= '0;                     // idle until next start
         end
         else begin
            count <= count + 1'b1;
         end
      end
   end

   // -------------------------------------------------------------------------
   // phase flags
   // -------------------------------------------------------------------------
   assign clearChain = startPls;                          // fresh division
   assign dataPhase = startPls || (count < dataEnd);      // feedback from data
   assign parityPhase = (count > dataEnd);                // output from parity

endmodule

/* src/rsOutputSelector.sv */
// Output selector of the Reed-Solomon encoder.
// Holds the last data symbol and the last parity tail on enabled
// edges and registers one of them onto the output stream on every
// clock edge, so the output stays put while the frame is stalled.

`timescale 1ns/1ps

module rsOutputSelector (
   input  logic                               CLK,
   input  logic                               RESET,
   input  logic                               enable,
   input  logic                               parityPhase,
   input  logic [rsFieldPkg::symbolWidth-1:0] dataIn,
   input  logic [rsFieldPkg::symbolWidth-1:0] parityTail,
   output logic [rsFieldPkg::symbolWidth-1:0] dataOut
);

   logic [rsFieldPkg::symbolWidth-1:0] dataHold;
   logic [rsFieldPkg::symbolWidth-1:0] parityHold;
   logic [rsFieldPkg::symbolWidth-1:0] selected;

   // -------------------------------------------------------------------------
   // holding registers
   // -------------------------------------------------------------------------
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         dataHold <= '0;
         parityHold <= '0;
      end
      else if (enable) begin
         dataHold <= dataIn;
         parityHold <= parityTail;           // one symbol behind the chain
      end
   end

   assign selected = parityPhase ? parityHold : dataHold;

   // -------------------------------------------------------------------------
   // output register, loads regardless of enable
   // -------------------------------------------------------------------------
   always_ff @(posedge CLK or negedge RESET) begin
      if (!RESET) begin
         dataOut <= '0;
      end
      else begin
         dataOut <= selected;
      end
   end

endmodule

/* src/rsParityGenerator.sv */
// Parity generator of the Reed-Solomon encoder.
// An LFSR of constant GF(2^8) multipliers divides data(x)*x^n by
// the generator polynomial. After the last data symbol the chain
// holds the remainder and shifts it out of the tail, highest
// coefficient first.

`timescale 1ns/1ps

module rsParityGenerator #(
   parameter int parityLength = rsFramePkg::paritySymbols
) (
   input  logic                               CLK,
   input  logic                               RESET,
   input  logic                               enable,
   input  logic                               clearChain,
   input  logic                               dataPhase,
   input  logic [rsFieldPkg::symbolWidth-1:0] dataIn,
   output logic [rsFieldPkg::symbolWidth-1:0] parityTail
);

   logic [rsFieldPkg::symbolWidth-1:0] feedback;
   logic [rsFieldPkg::symbolWidth-1:0] chain [parityLength];

   assign parityTail = chain[parityLength-1];

   // -------------------------------------------------------------------------
   // feedback symbol
   // -------------------------------------------------------------------------
   always_comb begin
      if (clearChain) begin
         feedback = dataIn;                  // tail counts as zero
      end
      else if (dataPhase) begin
         feedback = dataIn ^ parityTail;
      end
      else begin
         feedback = '0;                      // parity shift-out
      end
   end

   // -------------------------------------------------------------------------
   // division stages
   // -------------------------------------------------------------------------
   genvar i;
   generate
      for (i = 0; i < parityLength; i++) begin : stageLoop
         // coefficient of x^i, the monic x^n term is implicit
         localparam logic [rsFieldPkg::symbolWidth-1:0] stageCoeff =
            rsFieldPkg::generatorCoeff(parityLength, i);

         logic [rsFieldPkg::symbolWidth-1:0] product;
         logic [rsFieldPkg::symbolWidth-1:0] prevStage;

         // constant operand, reduces to an XOR matrix
         assign product = rsFieldPkg::gfMul(feedback, stageCoeff);

         if (i == 0) begin : headStage
            assign prevStage = '0;
         end
         else begin : innerStage
            assign prevStage = chain[i-1];
         end

         always_ff @(posedge CLK or negedge RESET) begin
            if (!RESET) begin
               chain[i] <= '0;
            end
            else if (enable) begin
               if (clearChain) begin
                  chain[i] <= product;       // drop the previous frame
               end
               else begin
                  chain[i] <= prevStage ^ product;
               end
            end
         end
      end
   endgenerate

endmodule

/* tests/rsEncoderTb.sv */
// Testbench for the Reed-Solomon encoder.
// Reads frame recipes from the golden file, drives frames with and
// without enable stalls, and checks the output stream against a
// table-based polynomial division model and the golden parity.

`timescale 1ns/1ps

module rsEncoderTb;

   localparam int frameCount = 6;
   localparam int lineFields = 20;          // s, d, stall, known, 16 parity
   localparam int dataLen = rsFramePkg::dataSymbols;
   localparam int parLen = rsFramePkg::paritySymbols;
   localparam int cwLen = rsFramePkg::codewordSymbols;
   localparam int clkPeriod = 40;
   localparam int watchdogCycles = frameCount * cwLen * 4 + 100;

   logic       CLK;
   logic       RESET;
   logic       enable;
   logic       startPls;
   logic [7:0] dataIn;
   wire  [7:0] dataOut;

   logic [7:0] goldenMem [0:frameCount*lineFields-1];
   logic [7:0] expTable [0:254];
   int         logTable [0:255];
   logic [7:0] genPoly [0:16];
   logic [7:0] modelMsg [0:207];
   logic [7:0] expParity [0:15];
   logic [7:0] driveExp;                    // symbol of the edge being driven
   logic [7:0] refQueue [$];
   logic [7:0] outExp;                      // symbol dataOut shows after an edge
   logic       outValid;
   integer     seed;

   rsEncoderTop dut0 (
      .CLK      (CLK),
      .RESET    (RESET),
      .enable   (enable),
      .startPls (startPls),
      .dataIn   (dataIn),
      .dataOut  (dataOut)
   );

   always #(clkPeriod/2) CLK = ~CLK;

   // --------------------------------------------------------------------------
   // GF(2^8) model, log and antilog tables
   // --------------------------------------------------------------------------
   function automatic logic [7:0] tableMul(input logic [7:0] a, input logic [7:0] b);
      if ((a == 8'h00) || (b == 8'h00)) begin
         return 8'h00;
      end
      return expTable[(logTable[a] + logTable[b]) % 255];
   endfunction

   task automatic buildTables();
      int x;
      int i;
      x = 1;
      for (i = 0; i < 255; i++) begin
         expTable[i] = 8'(x);
         logTable[x] = i;
         x = x << 1;
         if ((x & 256) != 0) begin
            x = x ^ 'h11D;                  // field polynomial
         end
      end
   endtask

   // g(x) = (x + a^0)(x + a^1)...(x + a^15), genPoly[16] is the monic term
   task automatic buildGenerator();
      int j;
      int k;
      for (k = 0; k <= parLen; k++) begin
         genPoly[k] = 8'h00;
      end
      genPoly[0] = 8'h01;
      for (j = 0; j < parLen; j++) begin
         for (k = j + 1; k > 0; k--) begin
            genPoly[k] = genPoly[k-1] ^ tableMul(genPoly[k], expTable[j]);
         end
         genPoly[0] = tableMul(genPoly[0], expTable[j]);
      end
   endtask

   // long division of data(x)*x^16, highest degree first
   task automatic modelParity(input logic [7:0] s, input logic [7:0] d);
      int i;
      int j;
      logic [7:0] lead;
      for (i = 0; i < cwLen; i++) begin
         modelMsg[i] = (i < dataLen) ? 8'(s + i * d) : 8'h00;
      end
      for (i = 0; i < dataLen; i++) begin
         lead = modelMsg[i];
         for (j = 1; j <= parLen; j++) begin
            modelMsg[i+j] = modelMsg[i+j] ^ tableMul(lead, genPoly[parLen-j]);
         end
      end
      for (j = 0; j < parLen; j++) begin
         expParity[j] = modelMsg[dataLen+j];   // x^15 coefficient first
      end
   endtask

   // --------------------------------------------------------------------------
   // compare, stop at first mismatch
   // --------------------------------------------------------------------------
   task automatic checkEqual(input string name, input logic [7:0] got,
                             input logic [7:0] exp);
      if (got !== exp) begin
         $display("ERROR %s got 0x%02h expected 0x%02h at %0t", name, got, exp, $time);
         $display("Verification failed");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic driveIdle(input int cycles);
      repeat (cycles) begin
         @(negedge CLK);
         enable = 1'b1;
         startPls = 1'b0;
         dataIn = 8'h00;
         driveExp = 8'h00;                  // idle shows the data hold
      end
   endtask

   task automatic sendFrame(input int f);
      int base;
      int pos;
      int j;
      logic [7:0] s;
      logic [7:0] d;
      logic stall;
      logic [7:0] par [0:15];
      base = f * lineFields;
      s = goldenMem[base];
      d = goldenMem[base+1];
      stall = (goldenMem[base+2] != 8'h00);
      modelParity(s, d);
      for (j = 0; j < parLen; j++) begin
         par[j] = expParity[j];
         if (goldenMem[base+3] != 8'h00) begin
            checkEqual("modelParity", expParity[j], goldenMem[base+4+j]);
            par[j] = goldenMem[base+4+j];
         end
      end
      for (pos = 0; pos < cwLen; pos++) begin
         if (stall) begin
            while (($random(seed) & 3) == 0) begin
               @(negedge CLK);
               enable = 1'b0;
               startPls = 1'b0;
               dataIn = 8'($random(seed));  // must be ignored
            end
         end
         @(negedge CLK);
         enable = 1'b1;
         startPls = (pos == 0);
         if (pos < dataLen) begin
            dataIn = 8'(s + pos * d);
            driveExp = 8'(s + pos * d);
         end
         else begin
            dataIn = 8'($random(seed));     // ignored during parity
            driveExp = par[pos-dataLen];
         end
      end
   endtask

   // --------------------------------------------------------------------------
   // reference stream and checker
   // --------------------------------------------------------------------------
   always @(posedge CLK) begin
      if (RESET) begin
         // this edge loads the symbol of the latest enabled edge before it
         if (refQueue.size() == 0) begin
            outExp = 8'h00;
         end
         else begin
            outExp = refQueue[$];
         end
         outValid = 1'b1;
         if (enable) begin
            refQueue.push_back(driveExp);
            if (refQueue.size() > 4) begin
               void'(refQueue.pop_front());
            end
         end
      end
   end

   always @(negedge CLK) begin
      if (outValid) begin
         checkEqual("dataOut", dataOut, outExp);
      end
   end

   initial begin
      repeat (watchdogCycles) @(posedge CLK);
      $display("watchdog expired, the run took longer than the frames allow");
      $display("Verification failed");
      $fatal(1, "timeout");
   end

   // --------------------------------------------------------------------------
   // main sequence
   // --------------------------------------------------------------------------
   initial begin
      int f;
      seed = 32'h8be0_df90;
      CLK = 1'b0;
      RESET = 1'b0;
      enable = 1'b0;
      startPls = 1'b0;
      dataIn = 8'h00;
      driveExp = 8'h00;
      outExp = 8'h00;
      outValid = 1'b0;
      $readmemh("tests/rsEncoder_golden.txt", goldenMem);
      buildTables();
      buildGenerator();
      repeat (2) @(negedge CLK);
      RESET = 1'b1;
      driveIdle(3);                         // output stays 0 before a start
      for (f = 0; f < frameCount; f++) begin
         if (f == 3) begin
            driveIdle(5);                   // one gap, the rest back to back
         end
         sendFrame(f);
      end
      driveIdle(4);
      @(negedge CLK);
      $display("Verification passed");
      $finish;
   end

endmodule

/* tests/rsEncoder_asserts.sv */
// Concurrent checks on the Reed-Solomon frame sequencer.
// Bound into every rsFrameSequencer instance; watches the phase
// flags and the position counter.

`timescale 1ns/1ps

module rsEncoderAsserts #(
   parameter int codewordLength = rsFramePkg::codewordSymbols
) (
   input logic                             CLK,
   input logic                             RESET,
   input logic                             enable,
   input logic                             clearChain,
   input logic                             dataPhase,
   input logic                             parityPhase,
   input logic [rsFramePkg::countWidth-1:0] count
);

   // the two phases exclude each other, a restart may cut into parity
   phaseExclusive: assert property (@(posedge CLK) disable iff (!RESET)
      !clearChain |-> !(dataPhase && parityPhase))
      else $error("dataPhase and parityPhase are both high");

   countInRange: assert property (@(posedge CLK) disable iff (!RESET)
      (count <= codewordLength))   // never past the last position
      else $error("count ran past the codeword length");

   // a taken start lands on position 1
   startLoadsOne: assert property (@(posedge CLK) disable iff (!RESET)
      (clearChain && enable) |=> (count == 1))
      else $error("count is not 1 after a start");

endmodule

bind rsFrameSequencer rsEncoderAsserts #(
   .codewordLength (codewordLength)
) asserts0 (
   .CLK         (CLK),
   .RESET       (RESET),
   .enable      (enable),
   .clearChain  (clearChain),
   .dataPhase   (dataPhase),
   .parityPhase (parityPhase),
   .count       (count)
);

/* tests/rsEncoder_golden.txt */
// start step stall known | parity x^15 .. x^0 (used when known is 01)
// data byte i = start + i*step mod 256; known 00 means model division only
00 00 00 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
5a 03 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
ff 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
37 0b 01 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
c4 fe 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00

/* verilog.f */
src/rsFieldPkg.sv
src/rsFramePkg.sv
src/rsFrameSequencer.sv
src/rsParityGenerator.sv
src/rsOutputSelector.sv
src/rsEncoderTop.sv
tests/rsEncoder_asserts.sv
tests/rsEncoderTb.sv
